// File: include/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Datapath width of the core
`define EX_XLEN 32

// Register file address width
`define EX_RF_AW 5

// Multiplier cycles from accept to result in EX/WB
`define EX_MUL_LAT 2

// One restoring step per quotient bit
`define EX_DIV_STEPS 32

`endif

// File: rtl/ex_op_pkg.sv
`default_nettype none

package ex_op_pkg;

  // Functional unit that serves the instruction in EX
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2,
    UNIT_CSR = 2'd3
  } unit_sel_e;

  // ALU operators, compare group in the upper half
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // Divider operators
  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_op_e;

endpackage

`default_nettype wire

// File: rtl/ex_pipe_pkg.sv
`default_nettype none

`include "ex_params.svh"

package ex_pipe_pkg;

  // EX/WB pipeline register, 72 bits
  typedef struct packed {
    logic                 instr_valid;
    logic                 rf_we;
    logic [`EX_RF_AW-1:0] rf_waddr;
    logic [`EX_XLEN-1:0]  rf_wdata;
    // Set by an illegal CSR access
    logic                 illegal_insn;
    logic [`EX_XLEN-1:0]  pc;
  } ex_wb_pipe_t;

  // Bubble with no write
  localparam ex_wb_pipe_t EX_WB_RESET = '0;

endpackage

`default_nettype wire

// File: rtl/ex_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

interface ex_issue_if import ex_op_pkg::*; ();

  // Handshake
  logic                 valid;
  logic                 ready;

  // Unit select and operators of each unit
  unit_sel_e            unit;
  alu_op_e              alu_op;
  mul_op_e              mul_op;
  div_op_e              div_op;

  // Operands
  logic [`EX_XLEN-1:0]  op_a;
  logic [`EX_XLEN-1:0]  op_b;

  // Destination and program counter
  logic [`EX_RF_AW-1:0] rf_waddr;
  logic                 rf_we;
  logic [`EX_XLEN-1:0]  pc;

  // Issuing side, holds all fields while valid and not ready
  modport src (
    output valid, unit, alu_op, mul_op, div_op, op_a, op_b, rf_waddr, rf_we, pc,
    input  ready
  );

  // Execute stage side
  modport dst (
    input  valid, unit, alu_op, mul_op, div_op, op_a, op_b, rf_waddr, rf_we, pc,
    output ready
  );

endinterface

`default_nettype wire

// File: rtl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_alu import ex_op_pkg::*; (
  input  alu_op_e             operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  logic                sub_en;
  logic [`EX_XLEN-1:0] adder_b;
  logic [`EX_XLEN-1:0] adder_res;
  logic [4:0]          shamt;
  logic                is_eq;
  logic                is_lt_s;
  logic                is_lt_u;

  // Shared adder, subtract by inverting b and carrying in one
  assign sub_en    = (operator_i == ALU_SUB);
  assign adder_b   = sub_en ? ~operand_b_i : operand_b_i;
  assign adder_res = operand_a_i + adder_b + {{(`EX_XLEN-1){1'b0}}, sub_en};

  // Shift amount from the low five bits of b
  assign shamt = operand_b_i[4:0];

  // Comparator
  assign is_eq   = (operand_a_i == operand_b_i);
  assign is_lt_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_lt_u = (operand_a_i < operand_b_i);

  // Compare result, also the branch decision
  always_comb begin
    case (operator_i)
      ALU_EQ:             cmp_result_o = is_eq;
      ALU_NE:             cmp_result_o = !is_eq;
      ALU_SLT, ALU_LT:    cmp_result_o = is_lt_s;
      ALU_GE:             cmp_result_o = !is_lt_s;
      ALU_SLTU, ALU_LTU:  cmp_result_o = is_lt_u;
      ALU_GEU:            cmp_result_o = !is_lt_u;
      default:            cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_res;
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = operand_a_i << shamt;
      ALU_SRL:          result_o = operand_a_i >> shamt;
      ALU_SRA:          result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Set-less-than and branch compares write the flag zero-extended
      default:          result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ex_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_mult import ex_op_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  mul_op_e             operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                valid_i,
  output logic                ready_o,
  output logic                valid_o,
  input  logic                ready_i,
  output logic [`EX_XLEN-1:0] result_o
);

  logic                    sign_a;
  logic                    sign_b;
  logic signed [`EX_XLEN:0] a_ext;
  logic signed [`EX_XLEN:0] b_ext;
  logic signed [2*`EX_XLEN+1:0] prod_full;
  logic [2*`EX_XLEN-1:0]   prod_q;
  logic                    hi_sel_q;
  logic                    busy_q;

  // Sign modes: mulh both signed, mulhsu only a, mulhu and mul none
  assign sign_a = (operator_i == MUL_MULH) || (operator_i == MUL_MULHSU);
  assign sign_b = (operator_i == MUL_MULH);

  // 33-bit operands
  assign a_ext = $signed({sign_a & op_a_i[`EX_XLEN-1], op_a_i});
  assign b_ext = $signed({sign_b & op_b_i[`EX_XLEN-1], op_b_i});

  // Full signed product of the extended operands
  assign prod_full = a_ext * b_ext;

  // Stage one holds a product until it is handed downstream
  // A dropped instruction clears the stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (!valid_i) begin
      busy_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q <= 1'b1;
    end else if (ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // Product and word select, loaded on accept
  always_ff @(posedge clk) begin
    if (valid_i && !busy_q) begin
      prod_q   <= prod_full[2*`EX_XLEN-1:0];
      hi_sel_q <= (operator_i != MUL_MUL);
    end
  end

  // Stage two, word select
  assign result_o = hi_sel_q ? prod_q[2*`EX_XLEN-1:`EX_XLEN] : prod_q[`EX_XLEN-1:0];
  assign valid_o  = busy_q;

  // Low while accepting and while a product waits downstream
  assign ready_o = busy_q ? ready_i : !valid_i;

endmodule

`default_nettype wire

// File: rtl/ex_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_div import ex_op_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  div_op_e             operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                valid_i,
  output logic                ready_o,
  output logic                valid_o,
  input  logic                ready_i,
  output logic [`EX_XLEN-1:0] result_o
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_e;

  div_state_e          state_q;
  logic [5:0]          cnt_q;
  logic                last_step;
  logic                signed_op;
  logic                a_neg;
  logic                b_neg;
  logic [`EX_XLEN-1:0] divisor_q;
  logic [`EX_XLEN-1:0] quo_q;
  logic [`EX_XLEN-1:0] rem_q;
  logic                rem_sel_q;
  logic                q_neg_q;
  logic                r_neg_q;
  logic [`EX_XLEN:0]   shifted;
  logic [`EX_XLEN:0]   diff;
  logic [`EX_XLEN-1:0] quo_fix;
  logic [`EX_XLEN-1:0] rem_fix;

  assign signed_op = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign a_neg     = signed_op & op_a_i[`EX_XLEN-1];
  assign b_neg     = signed_op & op_b_i[`EX_XLEN-1];
  assign last_step = (cnt_q == 6'(`EX_DIV_STEPS - 1));

  // Restoring step: shift in next dividend bit, try subtract
  assign shifted = {rem_q, quo_q[`EX_XLEN-1]};
  assign diff    = shifted - {1'b0, divisor_q};

  ////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (valid_i) begin
            state_q <= RUN;
            cnt_q   <= '0;
          end
        end
        RUN: begin
          // Killed or halted mid-run, start over later
          if (!valid_i) begin
            state_q <= IDLE;
          end else if (last_step) begin
            state_q <= DONE;
          end else begin
            cnt_q <= cnt_q + 6'd1;
          end
        end
        DONE: begin
          if (!valid_i || ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == IDLE && valid_i) begin
      // Work on magnitudes
      quo_q     <= a_neg ? -op_a_i : op_a_i;
      divisor_q <= b_neg ? -op_b_i : op_b_i;
      rem_q     <= '0;
      rem_sel_q <= (operator_i == DIV_REM) || (operator_i == DIV_REMU);
      // Zero divisor keeps the all-ones quotient unsigned
      q_neg_q   <= (a_neg ^ b_neg) && (op_b_i != '0);
      r_neg_q   <= a_neg;
    end else if (state_q == RUN) begin
      quo_q <= {quo_q[`EX_XLEN-2:0], ~diff[`EX_XLEN]};
      rem_q <= diff[`EX_XLEN] ? shifted[`EX_XLEN-1:0] : diff[`EX_XLEN-1:0];
    end
  end

  // Sign fix; overflow case falls out as quotient equal to dividend
  assign quo_fix  = q_neg_q ? -quo_q : quo_q;
  assign rem_fix  = r_neg_q ? -rem_q : rem_q;
  assign result_o = rem_sel_q ? rem_fix : quo_fix;

  assign valid_o = (state_q == DONE);
  assign ready_o = (state_q == IDLE) ? !valid_i : ((state_q == DONE) && ready_i);

endmodule

`default_nettype wire

// File: rtl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage import ex_op_pkg::*; import ex_pipe_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  ex_issue_if.dst             issue,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,
  input  logic                csr_illegal_i,
  input  logic                kill_i,
  input  logic                halt_i,
  input  logic                wb_ready_i,
  output ex_wb_pipe_t         ex_wb_pipe_o,
  output logic                branch_decision_o
);

  logic                instr_valid;
  logic                mul_en;
  logic                div_en;
  logic                csr_illegal;
  logic [`EX_XLEN-1:0] mul_op_a;
  logic [`EX_XLEN-1:0] mul_op_b;
  logic [`EX_XLEN-1:0] div_op_a;
  logic [`EX_XLEN-1:0] div_op_b;
  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN-1:0] mul_result;
  logic                mul_ready;
  logic                mul_valid;
  logic [`EX_XLEN-1:0] div_result;
  logic                div_ready;
  logic                div_valid;
  logic [`EX_XLEN-1:0] ex_wdata;
  logic                ex_valid;

  // Instruction counts only when neither killed nor halted
  assign instr_valid = issue.valid && !kill_i && !halt_i;

  // Unit enables and operand gating
  assign mul_en   = instr_valid && (issue.unit == UNIT_MUL);
  assign div_en   = instr_valid && (issue.unit == UNIT_DIV);
  assign mul_op_a = mul_en ? issue.op_a : '0;
  assign mul_op_b = mul_en ? issue.op_b : '0;
  assign div_op_a = div_en ? issue.op_a : '0;
  assign div_op_b = div_en ? issue.op_b : '0;

  // Illegal flag only matters for CSR reads
  assign csr_illegal = csr_illegal_i && (issue.unit == UNIT_CSR);

  ////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (issue.alu_op),
    .operand_a_i  (issue.op_a),
    .operand_b_i  (issue.op_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (issue.mul_op),
    .op_a_i     (mul_op_a),
    .op_b_i     (mul_op_b),
    .valid_i    (mul_en),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result)
  );

  ex_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (issue.div_op),
    .op_a_i     (div_op_a),
    .op_b_i     (div_op_b),
    .valid_i    (div_en),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .ready_i    (wb_ready_i),
    .result_o   (div_result)
  );

  assign branch_decision_o = alu_cmp;

  // Write data by unit
  always_comb begin
    case (issue.unit)
      UNIT_MUL: ex_wdata = mul_result;
      UNIT_DIV: ex_wdata = div_result;
      UNIT_CSR: ex_wdata = csr_rdata_i;
      default:  ex_wdata = alu_result;
    endcase
  end

  // ALU and CSR finish in the cycle they are presented
  always_comb begin
    case (issue.unit)
      UNIT_MUL: ex_valid = instr_valid && mul_valid;
      UNIT_DIV: ex_valid = instr_valid && div_valid;
      default:  ex_valid = instr_valid;
    endcase
  end

  // Kill frees EX at once, halt holds it
  assign issue.ready = kill_i || (mul_ready && div_ready && wb_ready_i && !halt_i);

  ////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_pipe_o <= EX_WB_RESET;
    end else if (ex_valid && wb_ready_i) begin
      ex_wb_pipe_o.instr_valid  <= 1'b1;
      // Illegal CSR access writes nothing
      ex_wb_pipe_o.rf_we        <= issue.rf_we && !csr_illegal;
      ex_wb_pipe_o.rf_waddr     <= issue.rf_waddr;
      ex_wb_pipe_o.rf_wdata     <= ex_wdata;
      ex_wb_pipe_o.illegal_insn <= csr_illegal;
      ex_wb_pipe_o.pc           <= issue.pc;
    end else if (wb_ready_i) begin
      // Bubble, no write and no flag
      ex_wb_pipe_o.instr_valid  <= 1'b0;
      ex_wb_pipe_o.rf_we        <= 1'b0;
      ex_wb_pipe_o.illegal_insn <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_top import ex_op_pkg::*; import ex_pipe_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // Issue from decode
  input  logic                 issue_valid_i,
  output logic                 issue_ready_o,
  input  logic [1:0]           issue_unit_i,
  input  logic [3:0]           issue_op_i,
  input  logic [`EX_XLEN-1:0]  issue_op_a_i,
  input  logic [`EX_XLEN-1:0]  issue_op_b_i,
  input  logic [`EX_RF_AW-1:0] issue_rd_i,
  input  logic                 issue_we_i,
  input  logic [`EX_XLEN-1:0]  issue_pc_i,
  // CSR read path and controller
  input  logic [`EX_XLEN-1:0]  csr_rdata_i,
  input  logic                 csr_illegal_i,
  input  logic                 kill_i,
  input  logic                 halt_i,
  // Writeback
  input  logic                 wb_ready_i,
  output logic                 wb_valid_o,
  output logic                 wb_we_o,
  output logic [`EX_RF_AW-1:0] wb_rd_o,
  output logic [`EX_XLEN-1:0]  wb_wdata_o,
  output logic                 wb_illegal_o,
  output logic [`EX_XLEN-1:0]  wb_pc_o,
  output logic                 branch_decision_o
);

  ex_wb_pipe_t ex_wb_pipe;

  ex_issue_if issue_if ();

  // Pack issue ports, op field cast per unit
  assign issue_if.valid    = issue_valid_i;
  assign issue_if.unit     = unit_sel_e'(issue_unit_i);
  assign issue_if.alu_op   = alu_op_e'(issue_op_i);
  assign issue_if.mul_op   = mul_op_e'(issue_op_i[1:0]);
  assign issue_if.div_op   = div_op_e'(issue_op_i[1:0]);
  assign issue_if.op_a     = issue_op_a_i;
  assign issue_if.op_b     = issue_op_b_i;
  assign issue_if.rf_waddr = issue_rd_i;
  assign issue_if.rf_we    = issue_we_i;
  assign issue_if.pc       = issue_pc_i;
  assign issue_ready_o     = issue_if.ready;

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue             (issue_if.dst),
    .csr_rdata_i       (csr_rdata_i),
    .csr_illegal_i     (csr_illegal_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .wb_ready_i        (wb_ready_i),
    .ex_wb_pipe_o      (ex_wb_pipe),
    .branch_decision_o (branch_decision_o)
  );

  // Unpack EX/WB
  assign wb_valid_o   = ex_wb_pipe.instr_valid;
  assign wb_we_o      = ex_wb_pipe.rf_we;
  assign wb_rd_o      = ex_wb_pipe.rf_waddr;
  assign wb_wdata_o   = ex_wb_pipe.rf_wdata;
  assign wb_illegal_o = ex_wb_pipe.illegal_insn;
  assign wb_pc_o      = ex_wb_pipe.pc;

endmodule

`default_nettype wire

// File: dv/ex_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ex_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset low for two rising edges, released off the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/ex_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ex_sva import ex_pipe_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        halt_i,
  input logic        issue_valid_i,
  input logic        issue_ready_i,
  input logic [1:0]  issue_unit_i,
  input logic [3:0]  issue_alu_op_i,
  input logic [31:0] issue_op_a_i,
  input logic [31:0] issue_op_b_i,
  input logic [4:0]  issue_rd_i,
  input logic        issue_we_i,
  input logic [31:0] issue_pc_i,
  input ex_wb_pipe_t ex_wb_pipe_i
);

  // Source holds the instruction until it is taken
  a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_unit_i) &&
      $stable(issue_alu_op_i) && $stable(issue_op_a_i) && $stable(issue_op_b_i) &&
      $stable(issue_rd_i) && $stable(issue_we_i) && $stable(issue_pc_i))
    else $error("issue fields changed while stalled");

  // Halted cycle loads no valid result into EX/WB
  a_halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    halt_i |=> (!ex_wb_pipe_i.instr_valid || $stable(ex_wb_pipe_i)))
    else $error("EX/WB written while halted");

  // EX/WB empty in reset, stage ready once reset is released
  a_reset_clear: assert property (@(posedge clk)
    !rst_n |-> !ex_wb_pipe_i.instr_valid && !ex_wb_pipe_i.rf_we && !ex_wb_pipe_i.illegal_insn)
    else $error("EX/WB not cleared in reset");

  a_ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> issue_ready_i && !ex_wb_pipe_i.instr_valid)
    else $error("stage not idle after reset");

endmodule

bind ex_stage ex_sva u_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .halt_i         (halt_i),
  .issue_valid_i  (issue.valid),
  .issue_ready_i  (issue.ready),
  .issue_unit_i   (issue.unit),
  .issue_alu_op_i (issue.alu_op),
  .issue_op_a_i   (issue.op_a),
  .issue_op_b_i   (issue.op_b),
  .issue_rd_i     (issue.rf_waddr),
  .issue_we_i     (issue.rf_we),
  .issue_pc_i     (issue.pc),
  .ex_wb_pipe_i   (ex_wb_pipe_o)
);

`default_nettype wire

// File: dv/ex_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_tb import ex_op_pkg::*; ();

  localparam int N_ALU   = 120;
  localparam int N_MUL   = 40;
  localparam int N_DIV   = 24;
  localparam int N_CSR   = 8;
  localparam int N_MIX   = 120;
  localparam int N_TXN   = N_ALU + N_MUL + N_DIV + N_CSR + N_MIX;
  localparam int TIMEOUT = N_TXN * (`EX_DIV_STEPS + 4) + 100;

  // Expected EX/WB entry
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        we;
    logic        illegal;
    logic [31:0] pc;
    logic        cmp;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        issue_valid_i;
  logic        issue_ready_o;
  logic [1:0]  issue_unit_i;
  logic [3:0]  issue_op_i;
  logic [31:0] issue_op_a_i;
  logic [31:0] issue_op_b_i;
  logic [4:0]  issue_rd_i;
  logic        issue_we_i;
  logic [31:0] issue_pc_i;
  logic [31:0] csr_rdata_i;
  logic        csr_illegal_i;
  logic        kill_i;
  logic        halt_i;
  logic        wb_ready_i;
  logic        wb_valid_o;
  logic        wb_we_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_wdata_o;
  logic        wb_illegal_o;
  logic [31:0] wb_pc_o;
  logic        branch_decision_o;

  integer      seed;
  int          cycle_cnt;
  logic        pressure;
  logic [31:0] pc_next;
  exp_t        exp_q[$];

  ex_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_top UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_o     (issue_ready_o),
    .issue_unit_i      (issue_unit_i),
    .issue_op_i        (issue_op_i),
    .issue_op_a_i      (issue_op_a_i),
    .issue_op_b_i      (issue_op_b_i),
    .issue_rd_i        (issue_rd_i),
    .issue_we_i        (issue_we_i),
    .issue_pc_i        (issue_pc_i),
    .csr_rdata_i       (csr_rdata_i),
    .csr_illegal_i     (csr_illegal_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .wb_ready_i        (wb_ready_i),
    .wb_valid_o        (wb_valid_o),
    .wb_we_o           (wb_we_o),
    .wb_rd_o           (wb_rd_o),
    .wb_wdata_o        (wb_wdata_o),
    .wb_illegal_o      (wb_illegal_o),
    .wb_pc_o           (wb_pc_o),
    .branch_decision_o (branch_decision_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic exp_t ex_ref(input logic [1:0] unit, input logic [3:0] op,
                                  input logic [31:0] a, input logic [31:0] b,
                                  input logic we, input logic [31:0] csr,
                                  input logic ill);
    exp_t        r;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    logic        lt_s;
    logic        lt_u;
    r    = '0;
    r.we = we;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    // Compare flag, used for slt and the branch decision
    case (op)
      ALU_SLT, ALU_LT:   r.cmp = lt_s;
      ALU_SLTU, ALU_LTU: r.cmp = lt_u;
      ALU_EQ:            r.cmp = (a == b);
      ALU_NE:            r.cmp = (a != b);
      ALU_GE:            r.cmp = !lt_s;
      ALU_GEU:           r.cmp = !lt_u;
      default:           r.cmp = 1'b0;
    endcase
    case (unit)
      UNIT_ALU: begin
        case (op)
          ALU_ADD: r.wdata = a + b;
          ALU_SUB: r.wdata = a - b;
          ALU_AND: r.wdata = a & b;
          ALU_OR:  r.wdata = a | b;
          ALU_XOR: r.wdata = a ^ b;
          ALU_SLL: r.wdata = a << b[4:0];
          ALU_SRL: r.wdata = a >> b[4:0];
          ALU_SRA: r.wdata = $unsigned($signed(a) >>> b[4:0]);
          default: r.wdata = {31'b0, r.cmp};
        endcase
      end
      UNIT_MUL: begin
        // Product mod 2^64 of the sign- or zero-extended operands
        ea    = (op[1:0] == MUL_MULH || op[1:0] == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'h0, a};
        eb    = (op[1:0] == MUL_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        prod  = ea * eb;
        r.wdata = (op[1:0] == MUL_MUL) ? prod[31:0] : prod[63:32];
      end
      UNIT_DIV: begin
        if (b == 32'h0) begin
          r.wdata = (op[1:0] == DIV_DIV || op[1:0] == DIV_DIVU) ? 32'hffff_ffff : a;
        end else if ((op[1:0] == DIV_DIV || op[1:0] == DIV_REM) &&
                     a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          // Signed overflow
          r.wdata = (op[1:0] == DIV_DIV) ? a : 32'h0;
        end else begin
          case (op[1:0])
            DIV_DIV:  r.wdata = $signed(a) / $signed(b);
            DIV_REM:  r.wdata = $signed(a) % $signed(b);
            DIV_DIVU: r.wdata = a / b;
            default:  r.wdata = a % b;
          endcase
        end
      end
      default: begin
        r.wdata   = csr;
        r.we      = we && !ill;
        r.illegal = ill;
      end
    endcase
    return r;
  endfunction

  // Corner values a quarter of the time
  function automatic logic [31:0] pick_operand();
    logic [31:0] v;
    v = $random(seed);
    if ((v & 32'h3) == 32'h0) begin
      case ((v >> 2) % 5)
        0:       v = 32'h0000_0000;
        1:       v = 32'h0000_0001;
        2:       v = 32'hffff_ffff;
        3:       v = 32'h8000_0000;
        default: v = 32'h7fff_ffff;
      endcase
    end else begin
      v = $random(seed);
    end
    return v;
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
    assert (got === expv)
      else begin
        $display("ERR %0t %s got %h exp %h", $time, name, got, expv);
        $display("SIMULATION FAILED");
        $fatal(1);
      end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Issue driver
  //////////////////////////////////////////////////////////////////////

  // Called 2 ns after a rising edge, returns 2 ns after the taking edge
  task automatic issue_instr(input logic [1:0] unit, input logic [3:0] op,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] csr, input logic ill,
                             input logic kill, input int halt_cycles);
    exp_t e;
    int   n;
    logic taken;
    e    = ex_ref(unit, op, a, b, 1'b1, csr, ill);
    e.rd = $random(seed);
    e.pc = pc_next;
    pc_next = pc_next + 32'd4;
    issue_valid_i = 1'b1;
    issue_unit_i  = unit;
    issue_op_i    = op;
    issue_op_a_i  = a;
    issue_op_b_i  = b;
    issue_rd_i    = e.rd;
    issue_we_i    = 1'b1;
    issue_pc_i    = e.pc;
    csr_rdata_i   = csr;
    csr_illegal_i = ill;
    kill_i        = kill;
    n     = 0;
    taken = 1'b0;
    while (!taken) begin
      halt_i     = (n < halt_cycles);
      wb_ready_i = pressure ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      n++;
      // Branch decision for the branch compares
      if (unit == UNIT_ALU && op >= ALU_EQ) begin
        check_field("branch_decision_o", {31'b0, branch_decision_o}, {31'b0, e.cmp});
      end
      taken = issue_ready_o;
      if (taken && !kill) begin
        exp_q.push_back(e);
      end
      @(posedge clk);
      #2;
    end
    // Fixed latencies with no stall
    if (!pressure && halt_cycles == 0 && !kill) begin
      if (unit == UNIT_MUL) begin
        assert (n == `EX_MUL_LAT)
          else report_fail("multiplier result not taken two edges after issue");
      end else if (unit != UNIT_DIV) begin
        assert (n == 1)
          else report_fail("single-cycle instruction not taken on its first edge");
      end
    end
    issue_valid_i = 1'b0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    csr_illegal_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparing process
  //////////////////////////////////////////////////////////////////////

  // An entry is drained on a cycle with valid and ready
  initial begin
    exp_t e;
    forever begin
      @(negedge clk);
      if (rst_n && wb_valid_o && wb_ready_i) begin
        assert (exp_q.size() != 0)
          else report_fail("result at writeback with none expected");
        e = exp_q.pop_front();
        check_field("wb_rd_o", {27'b0, wb_rd_o}, {27'b0, e.rd});
        check_field("wb_wdata_o", wb_wdata_o, e.wdata);
        check_field("wb_we_o", {31'b0, wb_we_o}, {31'b0, e.we});
        check_field("wb_illegal_o", {31'b0, wb_illegal_o}, {31'b0, e.illegal});
        check_field("wb_pc_o", wb_pc_o, e.pc);
      end
    end
  end

  // Cycle budget
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT) begin
        report_fail("timeout, the run did not finish in its cycle budget");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          i;
    int          u;
    logic [31:0] r;
    seed          = 97604;
    pressure      = 1'b0;
    pc_next       = 32'h0000_1000;
    issue_valid_i = 1'b0;
    issue_unit_i  = 2'd0;
    issue_op_i    = 4'd0;
    issue_op_a_i  = 32'h0;
    issue_op_b_i  = 32'h0;
    issue_rd_i    = 5'd0;
    issue_we_i    = 1'b0;
    issue_pc_i    = 32'h0;
    csr_rdata_i   = 32'h0;
    csr_illegal_i = 1'b0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    wb_ready_i    = 1'b1;

    wait (rst_n === 1'b1);
    @(posedge clk);
    #2;

    // Random ALU operations
    for (i = 0; i < N_ALU; i++) begin
      issue_instr(UNIT_ALU, 4'($random(seed)), pick_operand(), pick_operand(), 32'h0, 1'b0,
                  1'b0, 0);
    end

    // All multiplier operators on corner operands
    for (i = 0; i < N_MUL; i++) begin
      issue_instr(UNIT_MUL, 4'(i % 4), pick_operand(), pick_operand(), 32'h0, 1'b0, 1'b0, 0);
    end

    // Divider corner cases, six per operator
    for (i = 0; i < N_DIV / 6; i++) begin
      issue_instr(UNIT_DIV, 4'(i), pick_operand(), 32'h0, 32'h0, 1'b0, 1'b0, 0);
      issue_instr(UNIT_DIV, 4'(i), 32'h8000_0000, 32'hffff_ffff, 32'h0, 1'b0, 1'b0, 0);
      issue_instr(UNIT_DIV, 4'(i), pick_operand(), pick_operand(), 32'h0, 1'b0, 1'b0, 0);
      issue_instr(UNIT_DIV, 4'(i), $random(seed), ($random(seed) & 32'hf) + 1, 32'h0, 1'b0,
                  1'b0, 0);
      issue_instr(UNIT_DIV, 4'(i), 32'hffff_fff9, 32'h0000_0002, 32'h0, 1'b0, 1'b0, 0);
      issue_instr(UNIT_DIV, 4'(i), pick_operand(), 32'hffff_ffff, 32'h0, 1'b0, 1'b0, 0);
    end

    // CSR reads, every other one illegal
    for (i = 0; i < N_CSR; i++) begin
      issue_instr(UNIT_CSR, 4'd0, 32'h0, 32'h0, $random(seed), 1'(i % 2), 1'b0, 0);
    end

    // Mixed traffic with back-pressure, halts and kills
    pressure = 1'b1;
    for (i = 0; i < N_MIX; i++) begin
      r = $random(seed);
      u = r[1:0];
      if (r[7:4] == 4'd0) begin
        issue_instr(2'(u), 4'($random(seed)), pick_operand(), pick_operand(), $random(seed),
                    1'b0, 1'b1, 0);
      end else begin
        issue_instr(2'(u), 4'($random(seed)), pick_operand(), pick_operand(), $random(seed),
                    r[8], 1'b0, (r[11:9] == 3'd0) ? int'(r[13:12]) + 1 : 0);
      end
    end

    // Drain the writeback side, then watch for any extra result
    pressure   = 1'b0;
    wb_ready_i = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (5) @(posedge clk);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
rtl/ex_op_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/ex_issue_if.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_div.sv
rtl/ex_stage.sv
rtl/ex_top.sv
dv/ex_clk_gen.sv
dv/ex_sva.sv
dv/ex_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module ex_tb -f sources.f -o Vex_tb

# The simulator exits non-zero on a fatal check, the log decides
./obj_dir/Vex_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^SIMULATION PASSED$" sim.log
